// File: project.f
src/bmuCfgPkg.sv
src/bmuOpPkg.sv
src/pipeStage.sv
src/bmuDecode.sv
src/baseAlu.sv
src/zbbUnit.sv
src/zbcUnit.sv
src/bitManipAlu.sv
src/bmuExecTop.sv
tb/bmuFlow_chk.sv
tb/bmuMonitor.sv
tb/bmuTb.sv

// File: run.sh
#!/bin/sh
# Build and run the execute unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module bmuTb -f project.f -o simv
./obj_dir/simv > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "TEST FAIL" sim.log; then
  exit 1
fi

// File: tb/bmuTb.sv
// Testbench top for the execute unit at XLEN 32, LFSR stimulus with random back-pressure
// Ends on a cycle limit when responses stop coming back
`timescale 1ns/10ps
`default_nettype none

module bmuTb;

  import bmuOpPkg::*;

  localparam int numReq     = 2000;
  localparam int cycleLimit = 4 * numReq + 100;   // Whole run incl. reset and drain

  logic        clk;
  logic        rstN;
  logic        reqValid;
  logic        reqReady;
  logic        respValid;
  logic        respReady;
  bmuReqT      req;
  bmuRespT     resp;
  int          errCount, reqCount, respCount;
  int          cycles = 0;
  int          sent;
  logic [15:0] lfsr   = 16'd56482;               // Fixed seed

  bmuExecTop #(.XLEN(32)) uut (
    .clk, .rstN, .reqValid, .req, .reqReady, .respValid, .resp, .respReady
  );

  bmuMonitor uMon (
    .clk, .rstN, .reqValid, .req, .reqReady, .respValid, .resp, .respReady,
    .errCount, .reqCount, .respCount
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;                       // 40 ns period
  end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  // Fibonacci LFSR x^16+x^14+x^13+x^11, one step per bit taken
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  // Corner values for 6 of 16 codes cover index 0 and 31 and the sign boundary
  function automatic logic [31:0] pickOperand();
    logic [3:0] kind;
    kind = 4'(randBits(4));
    case (kind)
      4'd0:    return 32'h0000_0000;
      4'd1:    return 32'hffff_ffff;
      4'd2:    return 32'h8000_0000;
      4'd3:    return 32'h7fff_ffff;
      4'd4:    return 32'h0000_0001;
      4'd5:    return 32'h0000_001f;              // Shift/bit index 31
      default: return randBits(32);
    endcase
  endfunction

  function automatic bmuReqT newRequest();
    bmuReqT     r;
    logic [5:0] opCode;
    opCode = 6'(randBits(6) % 37);                // 37 kept ops
    r.op   = bmuOpT'(opCode);
    r.tag  = 4'(randBits(4));
    r.a    = {32'h0, pickOperand()};
    r.b    = {32'h0, pickOperand()};
    return r;
  endfunction

  // Run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("TEST FAIL");
      $finish;
    end
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    rstN      = 1'b0;
    reqValid  = 1'b0;
    respReady = 1'b0;
    req       = '0;
    sent      = 0;
    repeat (16) @(posedge clk);
    rstN <= 1'b1;

    // Lone request, respReady held high for the latency check
    @(posedge clk);
    respReady <= 1'b1;
    reqValid  <= 1'b1;
    req       <= newRequest();
    do begin
      @(posedge clk);
    end while (!(reqValid && reqReady));
    reqValid <= 1'b0;
    sent = 1;
    while (respCount < 1) @(posedge clk);

    // Random traffic, request held while stalled
    while (sent < numReq) begin
      @(posedge clk);
      if (reqValid && reqReady) sent++;
      respReady <= (randBits(2) != 0);            // About 25% back-pressure
      if (!reqValid || reqReady) begin
        if (sent < numReq && randBits(2) != 0) begin
          reqValid <= 1'b1;
          req      <= newRequest();
        end else begin
          reqValid <= 1'b0;
        end
      end
    end

    // Drain
    @(posedge clk);
    respReady <= 1'b1;
    while (respCount < numReq) @(posedge clk);
    repeat (4) @(posedge clk);

    if (reqCount != respCount) begin
      $display("Request and response counts differ at the end of the run");
    end
    $display("requests %0d responses %0d errors %0d assertion failures %0d",
             reqCount, respCount, errCount, uut.uFlowChk.failCount);
    if (errCount == 0 && uut.uFlowChk.failCount == 0 && reqCount == respCount &&
        reqCount == numReq) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule : bmuTb

`default_nettype wire

// File: tb/bmuMonitor.sv
// Scoreboard for the execute unit, 32-bit reference model
// Responses must come back in request order, two edges after acceptance when not stalled
`timescale 1ns/10ps
`default_nettype none

module bmuMonitor (
  input  logic              clk,
  input  logic              rstN,
  input  logic              reqValid,
  input  bmuOpPkg::bmuReqT  req,
  input  logic              reqReady,
  input  logic              respValid,
  input  bmuOpPkg::bmuRespT resp,
  input  logic              respReady,
  output int                errCount,
  output int                reqCount,
  output int                respCount
);

  import bmuOpPkg::*;

  bmuReqT      pendQ[$];                          // Accepted, not yet answered
  int          acceptQ[$];                        // Acceptance cycle per entry
  bmuReqT      head;
  int          headCyc;
  int          lat;
  logic [63:0] expRes;
  int          errs      = 0;
  int          reqs      = 0;
  int          resps     = 0;
  int          cyc       = 0;
  int          lastStall = 0;                     // Last edge with respReady low
  int          rstEdges  = 0;

  assign errCount  = errs;
  assign reqCount  = reqs;
  assign respCount = resps;

  //////////////////////////////
  // Reference model
  //////////////////////////////
  function automatic logic [31:0] expectedResult(bmuOpT op, logic [31:0] a, logic [31:0] b);
    logic [4:0]  sh;
    logic [63:0] dbl;
    logic [63:0] prod;
    logic [31:0] r;
    int          n;
    sh   = b[4:0];
    dbl  = {a, a};                                // Rotates read a window of this
    prod = '0;
    for (int i = 0; i < 32; i++) begin
      if (b[i]) prod = prod ^ ({32'h0, a} << i);  // Full carry-less product
    end
    r = '0;
    n = 0;
    case (op)
      opAdd:    r = a + b;
      opSub:    r = a - b;
      opAnd:    r = a & b;
      opOr:     r = a | b;
      opXor:    r = a ^ b;
      opSll:    r = a << sh;
      opSrl:    r = a >> sh;
      opSra:    r = $unsigned($signed(a) >>> sh);
      opSlt:    r = {31'b0, $signed(a) < $signed(b)};
      opSltu:   r = {31'b0, a < b};
      opSh1add: r = (a << 1) + b;
      opSh2add: r = (a << 2) + b;
      opSh3add: r = (a << 3) + b;
      opAndn:   r = a & ~b;
      opOrn:    r = a | ~b;
      opXnor:   r = ~(a ^ b);
      opClz: begin
        while (n < 32 && !a[31-n]) n++;
        r = 32'(n);
      end
      opCtz: begin
        while (n < 32 && !a[n]) n++;
        r = 32'(n);
      end
      opCpop:   r = 32'($countones(a));
      opMin:    r = ($signed(a) < $signed(b)) ? a : b;
      opMinu:   r = (a < b) ? a : b;
      opMax:    r = ($signed(a) < $signed(b)) ? b : a;
      opMaxu:   r = (a < b) ? b : a;
      opSextB:  r = {{24{a[7]}}, a[7:0]};
      opSextH:  r = {{16{a[15]}}, a[15:0]};
      opZextH:  r = {16'h0, a[15:0]};
      opRol:    r = 32'(dbl >> (32 - int'(sh)));
      opRor:    r = 32'(dbl >> sh);
      opOrcB: begin
        for (int i = 0; i < 4; i++) r[8*i +: 8] = (a[8*i +: 8] != 0) ? 8'hff : 8'h00;
      end
      opRev8:   r = {a[7:0], a[15:8], a[23:16], a[31:24]};
      opClmul:  r = prod[31:0];
      opClmulh: r = prod[63:32];
      opClmulr: r = prod[62:31];
      opBset:   r = a | (32'h1 << sh);
      opBclr:   r = a & ~(32'h1 << sh);
      opBinv:   r = a ^ (32'h1 << sh);
      opBext:   r = {31'b0, a[sh]};
      default:  r = 'x;                           // Unused code, flags a mismatch
    endcase
    return r;
  endfunction

  //////////////////////////////
  // Scoreboard
  //////////////////////////////
  always @(posedge clk) begin
    cyc++;
    if (!rstN) begin
      rstEdges++;
      if (rstEdges > 1 && respValid !== 1'b0) begin   // First edge clears the stage
        $display("Response valid was high during reset at %0t", $time);
        errs++;
      end
    end else begin
      if (!respReady) lastStall = cyc;
      // Older entry leaves before a same-edge acceptance
      if (respValid && respReady) begin
        resps++;
        if (pendQ.size() == 0) begin
          $display("A response came back with no request outstanding at %0t", $time);
          errs++;
        end else begin
          head    = pendQ.pop_front();
          headCyc = acceptQ.pop_front();
          lat     = cyc - headCyc;
          expRes  = {32'h0, expectedResult(head.op, head.a[31:0], head.b[31:0])};
          if (resp.tag !== head.tag) begin
            $display("ERROR %0t resp.tag expected %h got %h", $time, head.tag, resp.tag);
            errs++;
          end
          if (resp.result !== expRes) begin
            $display("ERROR %0t resp.result expected %h got %h (%s a %h b %h)", $time,
                     expRes, resp.result, head.op.name(), head.a[31:0], head.b[31:0]);
            errs++;
          end
          if (lat < 2 || (lastStall <= headCyc && lat != 2)) begin
            $display("ERROR %0t latency expected 2 got %0d", $time, lat);
            errs++;
          end
        end
      end
      if (reqValid && reqReady) begin
        reqs++;
        pendQ.push_back(req);
        acceptQ.push_back(cyc);
      end
    end
  end

endmodule : bmuMonitor

`default_nettype wire

// File: tb/bmuFlow_chk.sv
// Valid/ready rules on both ports of the execute unit, bound into the top level
// Only active with assertions enabled in the simulator
`timescale 1ns/10ps
`default_nettype none

module bmuFlow_chk (
  input logic              clk,
  input logic              rstN,
  input logic              reqValid,
  input bmuOpPkg::bmuReqT  req,
  input logic              reqReady,
  input logic              respValid,
  input bmuOpPkg::bmuRespT resp,
  input logic              respReady
);

  int failCount = 0;                         // Failed assertion attempts

  // Both stages empty one edge after a reset cycle
  respIdleAfterReset: assert property (@(posedge clk) !rstN |=> !respValid)
    else begin
      $error("respValid high right after a reset cycle");
      failCount++;
    end

  //////////////////////////////
  // Stalled transfers hold
  //////////////////////////////
  reqHeld: assert property (@(posedge clk) disable iff (!rstN)
    reqValid && !reqReady |=> reqValid && $stable(req))
    else begin
      $error("Request dropped or changed while stalled");
      failCount++;
    end

  respHeld: assert property (@(posedge clk) disable iff (!rstN)
    respValid && !respReady |=> respValid)
    else begin
      $error("respValid dropped before its transfer");
      failCount++;
    end

  respStable: assert property (@(posedge clk) disable iff (!rstN)
    respValid && !respReady |=> $stable(resp))
    else begin
      $error("Response changed while stalled");
      failCount++;
    end

endmodule : bmuFlow_chk

bind bmuExecTop bmuFlow_chk uFlowChk (
  .clk, .rstN, .reqValid, .req, .reqReady, .respValid, .resp, .respReady
);

`default_nettype wire

// File: src/bmuExecTop.sv
// Two-cycle execute unit, responses return in request order
// Result bits above XLEN are zero
`timescale 1ns/10ps
`default_nettype none

module bmuExecTop #(
  parameter int XLEN = bmuCfgPkg::xlenDefault
) (
  input  logic              clk,
  input  logic              rstN,
  input  logic              reqValid,
  input  bmuOpPkg::bmuReqT  req,
  output logic              reqReady,
  output logic              respValid,
  output bmuOpPkg::bmuRespT resp,
  input  logic              respReady
);

  import bmuCfgPkg::*;
  import bmuOpPkg::*;

  bmuReqT          s1Req;
  logic            s1Valid, s1Ready;
  bmuCtrlT         ctrl;
  bmuRespT         s2In;
  logic [XLEN-1:0] condShiftA, condMaskB, preAluResult, fullResult, aluResult;
  logic            lt, ltu;

  ////////////////////////////////
  // Stage 1, registered request
  ////////////////////////////////
  pipeStage #(.payloadT(bmuReqT)) uReqStage (
    .clk, .rstN,
    .inValid (reqValid), .inData (req),   .inReady (reqReady),
    .outValid(s1Valid),  .outData(s1Req), .outReady(s1Ready)
  );

  bmuDecode uDecode (.op(s1Req.op), .ctrl);

  baseAlu #(.XLEN(XLEN)) uBaseAlu (
    .condShiftA, .condMaskB, .b(s1Req.b[XLEN-1:0]), .ctrl,
    .preAluResult, .fullResult, .lt, .ltu
  );

  bitManipAlu #(.XLEN(XLEN)) uBitManip (
    .a(s1Req.a[XLEN-1:0]), .b(s1Req.b[XLEN-1:0]), .ctrl, .lt, .ltu,
    .preAluResult, .fullResult, .condMaskB, .condShiftA, .aluResult
  );

  assign s2In = '{tag: s1Req.tag, result: maxXlen'(aluResult)};

  // Stage 2, registered response
  pipeStage #(.payloadT(bmuRespT)) uRespStage (
    .clk, .rstN,
    .inValid (s1Valid),   .inData (s2In), .inReady (s1Ready),
    .outValid(respValid), .outData(resp), .outReady(respReady)
  );

endmodule : bmuExecTop

`default_nettype wire

// File: src/bitManipAlu.sv
// Bit-manipulation front end and final result mux
// Operands are not gated, every accepted request uses the unit
`timescale 1ns/10ps
`default_nettype none

module bitManipAlu #(
  parameter int XLEN = bmuCfgPkg::xlenDefault
) (
  input  logic [XLEN-1:0]   a,
  input  logic [XLEN-1:0]   b,
  input  bmuOpPkg::bmuCtrlT ctrl,
  input  logic              lt,
  input  logic              ltu,
  input  logic [XLEN-1:0]   preAluResult,
  input  logic [XLEN-1:0]   fullResult,
  output logic [XLEN-1:0]   condMaskB,
  output logic [XLEN-1:0]   condShiftA,
  output logic [XLEN-1:0]   aluResult
);

  import bmuOpPkg::*;

  localparam int shW = $clog2(XLEN);

  logic            rotate, mask, preShift;
  logic [1:0]      preShiftAmt;
  logic [XLEN-1:0] maskB;                    // One-hot bit index from b
  logic [XLEN-1:0] revA;
  logic [XLEN-1:0] zbbResult, zbcResult;

  assign {rotate, mask, preShift} = ctrl.bAluControl;

  assign maskB     = {{(XLEN-1){1'b0}}, 1'b1} << b[shW-1:0];
  assign condMaskB = mask ? maskB : b;

  // shNadd shift amount sits in funct3[2:1]
  assign preShiftAmt = ctrl.funct3[2:1] & {2{preShift}};
  assign condShiftA  = a << preShiftAmt;

  // Reversed a feeds ctz and the reversed clmul forms
  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      revA[i] = a[XLEN-1-i];
    end
  end

  zbbUnit #(.XLEN(XLEN)) uZbb (
    .a         (a),
    .revA      (revA),
    .b         (b),
    .lt        (lt),
    .ltu       (ltu),
    .bUnsigned (ctrl.funct3[0]),
    .rotate    (rotate),
    .zbbSelect (ctrl.zbbSelect),
    .zbbResult (zbbResult)
  );

  zbcUnit #(.XLEN(XLEN)) uZbc (
    .a         (a),
    .revA      (revA),
    .b         (b),
    .funct3    (ctrl.funct3),
    .zbcResult (zbcResult)
  );

  always_comb begin
    case (ctrl.bSelect)
      alu:     aluResult = preAluResult;
      zbaZbs:  aluResult = fullResult;
      zbb:     aluResult = zbbResult;
      default: aluResult = zbcResult;        // zbc
    endcase
  end

endmodule : bitManipAlu

`default_nettype wire

// File: src/zbcUnit.sv
// Carry-less multiply; reversed forms reuse the low-half product loop
`timescale 1ns/10ps
`default_nettype none

module zbcUnit #(
  parameter int XLEN = bmuCfgPkg::xlenDefault
) (
  input  logic [XLEN-1:0] a,
  input  logic [XLEN-1:0] revA,
  input  logic [XLEN-1:0] b,
  input  logic [2:0]      funct3,
  output logic [XLEN-1:0] zbcResult
);

  logic [XLEN-1:0] revB, x, y;
  logic [XLEN-1:0] prod, revProd;

  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      revB[i] = b[XLEN-1-i];
    end
  end

  // funct3[1] marks clmulr/clmulh
  assign x = funct3[1] ? revA : a;
  assign y = funct3[1] ? revB : b;

  always_comb begin
    prod = '0;
    for (int i = 0; i < XLEN; i++) begin
      if (y[i]) prod = prod ^ (x << i);
    end
  end

  // Product read back from the top bit
  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      revProd[i] = prod[XLEN-1-i];
    end
  end

  always_comb begin
    case (funct3[1:0])
      2'b10:   zbcResult = revProd;          // clmulr
      2'b11:   zbcResult = revProd >> 1;     // clmulh
      default: zbcResult = prod;             // clmul
    endcase
  end

endmodule : zbcUnit

`default_nettype wire

// File: src/zbbUnit.sv
// ZBB results; min/max rely on lt/ltu from the base ALU subtract
`timescale 1ns/10ps
`default_nettype none

module zbbUnit #(
  parameter int XLEN = bmuCfgPkg::xlenDefault
) (
  input  logic [XLEN-1:0] a,
  input  logic [XLEN-1:0] revA,
  input  logic [XLEN-1:0] b,
  input  logic            lt,
  input  logic            ltu,
  input  logic            bUnsigned,
  input  logic            rotate,
  input  logic [2:0]      zbbSelect,
  output logic [XLEN-1:0] zbbResult
);

  import bmuOpPkg::*;

  localparam int shW  = $clog2(XLEN);
  localparam int cntW = shW + 1;             // Holds XLEN itself for zero input

  logic [XLEN-1:0] cntSrc;
  logic [cntW-1:0] lzc, pop;
  logic            seenOne;
  logic            less;
  logic [shW-1:0]  rotAmt;
  logic [XLEN-1:0] rolRes, rorRes;
  logic [XLEN-1:0] orcRes, rev8Res;
  logic [1:0]      sub;

  assign sub    = {rotate, bUnsigned};       // Sub-select inside a group
  assign cntSrc = bUnsigned ? revA : a;      // ctz is clz of the reversed word

  //////////////////////////////
  // Counts
  //////////////////////////////
  always_comb begin
    lzc     = '0;
    seenOne = 1'b0;
    for (int i = XLEN-1; i >= 0; i--) begin
      if (cntSrc[i]) seenOne = 1'b1;
      else if (!seenOne) lzc = lzc + 1'b1;
    end
  end

  always_comb begin
    pop = '0;
    for (int i = 0; i < XLEN; i++) begin
      pop = pop + cntW'(a[i]);
    end
  end

  assign less = bUnsigned ? ltu : lt;

  // Rotates, shift by XLEN yields zero so amount 0 is safe
  assign rotAmt = b[shW-1:0];
  assign rolRes = (a << rotAmt) | (a >> (XLEN - int'(rotAmt)));
  assign rorRes = (a >> rotAmt) | (a << (XLEN - int'(rotAmt)));

  // Byte ops
  always_comb begin
    for (int i = 0; i < XLEN/8; i++) begin
      orcRes[8*i +: 8]  = {8{|a[8*i +: 8]}};
      rev8Res[8*i +: 8] = a[XLEN-8-8*i +: 8];
    end
  end

  always_comb begin
    case (zbbSelect)
      zbbCount: zbbResult = rotate ? XLEN'(pop) : XLEN'(lzc);
      zbbMin:   zbbResult = less ? a : b;
      zbbMax:   zbbResult = less ? b : a;
      zbbRot:   zbbResult = rotate ? rolRes : rorRes;
      zbbByte:  zbbResult = bUnsigned ? rev8Res : orcRes;
      zbbExt: begin
        case (sub)
          2'b00:   zbbResult = {{(XLEN-8){a[7]}}, a[7:0]};
          2'b01:   zbbResult = {{(XLEN-16){a[15]}}, a[15:0]};
          default: zbbResult = {{(XLEN-16){1'b0}}, a[15:0]};
        endcase
      end
      zbbLogic: begin
        case (sub)
          2'b00:   zbbResult = a & ~b;       // andn
          2'b01:   zbbResult = a | ~b;       // orn
          default: zbbResult = ~(a ^ b);     // xnor
        endcase
      end
      default:  zbbResult = '0;
    endcase
  end

endmodule : zbbUnit

`default_nettype wire

// File: src/baseAlu.sv
// Integer ALU with one shared adder; compares need subtract set by decode
`timescale 1ns/10ps
`default_nettype none

module baseAlu #(
  parameter int XLEN = bmuCfgPkg::xlenDefault
) (
  input  logic [XLEN-1:0]   condShiftA,
  input  logic [XLEN-1:0]   condMaskB,
  input  logic [XLEN-1:0]   b,
  input  bmuOpPkg::bmuCtrlT ctrl,
  output logic [XLEN-1:0]   preAluResult,
  output logic [XLEN-1:0]   fullResult,
  output logic              lt,
  output logic              ltu
);

  import bmuOpPkg::*;

  localparam int shW = $clog2(XLEN);

  logic [XLEN:0]   sumC;                     // Sum with carry out
  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] addB;                     // b or its complement
  logic [shW-1:0]  shamt;
  logic [XLEN-1:0] shr;                      // Logical right shift, reused by bext

  assign addB  = ctrl.subtract ? ~condMaskB : condMaskB;
  assign sumC  = {1'b0, condShiftA} + {1'b0, addB} + {{XLEN{1'b0}}, ctrl.subtract};
  assign sum   = sumC[XLEN-1:0];
  assign shamt = b[shW-1:0];
  assign shr   = condShiftA >> shamt;

  // Signs differ: a negative means less, else the difference sign decides
  assign lt  = (condShiftA[XLEN-1] != condMaskB[XLEN-1]) ? condShiftA[XLEN-1] : sum[XLEN-1];
  assign ltu = !sumC[XLEN];                  // Borrow out of a - b

  always_comb begin
    case (ctrl.aluOp)
      aluSll:  preAluResult = condShiftA << shamt;
      aluSlt:  preAluResult = {{(XLEN-1){1'b0}}, lt};
      aluSltu: preAluResult = {{(XLEN-1){1'b0}}, ltu};
      aluXor:  preAluResult = condShiftA ^ condMaskB;
      aluSrl:  preAluResult = shr;
      aluSra:  preAluResult = $unsigned($signed(condShiftA) >>> shamt);
      aluOr:   preAluResult = condShiftA | condMaskB;
      aluAnd:  preAluResult = condShiftA & condMaskB;
      default: preAluResult = sum;           // add, sub
    endcase
  end

  // ZBA sum and ZBS forms
  always_comb begin
    case (ctrl.aluOp)
      aluBset: fullResult = condShiftA | condMaskB;
      aluBclr: fullResult = condShiftA & ~condMaskB;
      aluBinv: fullResult = condShiftA ^ condMaskB;
      aluBext: fullResult = {{(XLEN-1){1'b0}}, shr[0]};
      default: fullResult = sum;             // sh1add .. sh3add
    endcase
  end

endmodule : baseAlu

`default_nettype wire

// File: src/bmuDecode.sv
// Combinational op-code decode, unlisted codes fall back to add
`timescale 1ns/10ps
`default_nettype none

module bmuDecode (
  input  bmuOpPkg::bmuOpT   op,
  output bmuOpPkg::bmuCtrlT ctrl
);

  import bmuOpPkg::*;

  always_comb begin
    ctrl         = '0;                       // alu source, add, no pre-shift
    ctrl.bSelect = alu;
    case (op)
      opAdd:    ctrl.aluOp = aluAdd;
      opSub:    begin ctrl.aluOp = aluAdd; ctrl.subtract = 1'b1; end
      opAnd:    ctrl.aluOp = aluAnd;
      opOr:     ctrl.aluOp = aluOr;
      opXor:    ctrl.aluOp = aluXor;
      opSll:    ctrl.aluOp = aluSll;
      opSrl:    ctrl.aluOp = aluSrl;
      opSra:    ctrl.aluOp = aluSra;
      opSlt:    begin ctrl.aluOp = aluSlt;  ctrl.subtract = 1'b1; end
      opSltu:   begin ctrl.aluOp = aluSltu; ctrl.subtract = 1'b1; end
      // ZBA, funct3[2:1] is the pre-shift amount
      opSh1add: begin ctrl.bSelect = zbaZbs; ctrl.funct3 = 3'b010; ctrl.bAluControl = 3'b001; end
      opSh2add: begin ctrl.bSelect = zbaZbs; ctrl.funct3 = 3'b100; ctrl.bAluControl = 3'b001; end
      opSh3add: begin ctrl.bSelect = zbaZbs; ctrl.funct3 = 3'b110; ctrl.bAluControl = 3'b001; end
      // ZBS, one-hot mask replaces b
      opBset:   begin ctrl.bSelect = zbaZbs; ctrl.aluOp = aluBset; ctrl.bAluControl = 3'b010; end
      opBclr:   begin ctrl.bSelect = zbaZbs; ctrl.aluOp = aluBclr; ctrl.bAluControl = 3'b010; end
      opBinv:   begin ctrl.bSelect = zbaZbs; ctrl.aluOp = aluBinv; ctrl.bAluControl = 3'b010; end
      opBext:   begin ctrl.bSelect = zbaZbs; ctrl.aluOp = aluBext; end
      // ZBB
      opClz:    begin ctrl.bSelect = zbb; ctrl.zbbSelect = zbbCount; end
      opCtz:    begin ctrl.bSelect = zbb; ctrl.zbbSelect = zbbCount; ctrl.funct3 = 3'b001; end
      opCpop:   begin ctrl.bSelect = zbb; ctrl.zbbSelect = zbbCount; ctrl.bAluControl = 3'b100; end
      opMin:    begin ctrl.bSelect = zbb; ctrl.zbbSelect = zbbMin; ctrl.funct3 = 3'b100; ctrl.subtract = 1'b1; end
      opMinu:   begin ctrl.bSelect = zbb; ctrl.zbbSelect = zbbMin; ctrl.funct3 = 3'b101; ctrl.subtract = 1'b1; end
      opMax:    begin ctrl.bSelect = zbb; ctrl.zbbSelect = zbbMax; ctrl.funct3 = 3'b110; ctrl.subtract = 1'b1; end
      opMaxu:   begin ctrl.bSelect = zbb; ctrl.zbbSelect = zbbMax; ctrl.funct3 = 3'b111; ctrl.subtract = 1'b1; end
      opRol:    begin ctrl.bSelect = zbb; ctrl.zbbSelect = zbbRot; ctrl.bAluControl = 3'b100; end
      opRor:    begin ctrl.bSelect = zbb; ctrl.zbbSelect = zbbRot; end
      opOrcB:   begin ctrl.bSelect = zbb; ctrl.zbbSelect = zbbByte; end
      opRev8:   begin ctrl.bSelect = zbb; ctrl.zbbSelect = zbbByte; ctrl.funct3 = 3'b001; end
      opSextB:  begin ctrl.bSelect = zbb; ctrl.zbbSelect = zbbExt; end
      opSextH:  begin ctrl.bSelect = zbb; ctrl.zbbSelect = zbbExt; ctrl.funct3 = 3'b001; end
      opZextH:  begin ctrl.bSelect = zbb; ctrl.zbbSelect = zbbExt; ctrl.bAluControl = 3'b100; end
      opAndn:   begin ctrl.bSelect = zbb; ctrl.zbbSelect = zbbLogic; end
      opOrn:    begin ctrl.bSelect = zbb; ctrl.zbbSelect = zbbLogic; ctrl.funct3 = 3'b001; end
      opXnor:   begin ctrl.bSelect = zbb; ctrl.zbbSelect = zbbLogic; ctrl.bAluControl = 3'b100; end
      // ZBC, funct3 as in the ISA encoding
      opClmul:  begin ctrl.bSelect = zbc; ctrl.funct3 = 3'b001; end
      opClmulr: begin ctrl.bSelect = zbc; ctrl.funct3 = 3'b010; end
      opClmulh: begin ctrl.bSelect = zbc; ctrl.funct3 = 3'b011; end
      default:  ctrl.aluOp = aluAdd;
    endcase
  end

endmodule : bmuDecode

`default_nettype wire

// File: src/pipeStage.sv
// One-entry valid/ready slice, full throughput when downstream is ready
`timescale 1ns/10ps
`default_nettype none

module pipeStage #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    rstN,
  input  logic    inValid,
  input  payloadT inData,
  output logic    inReady,
  output logic    outValid,
  input  logic    outReady,
  output payloadT outData
);

  payloadT dataQ;                            // Payload register, no reset
  logic    validQ;

  assign inReady  = !validQ || outReady;     // Empty or draining this cycle
  assign outValid = validQ;
  assign outData  = dataQ;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      validQ <= 1'b0;
    end else if (inReady) begin
      validQ <= inValid;                     // Refill or go empty
    end
  end

  always_ff @(posedge clk) begin
    if (inValid && inReady) begin
      dataQ <= inData;                       // Load only on input transfer
    end
  end

endmodule : pipeStage

`default_nettype wire

// File: src/bmuOpPkg.sv
// Operation codes, decoded control and the request/response payloads
// Operand fields are sized for 64 bits, narrower datapaths use the low bits
`default_nettype none

package bmuOpPkg;

  import bmuCfgPkg::*;

  typedef enum logic [5:0] {
    opAdd, opSub, opAnd, opOr, opXor, opSll, opSrl, opSra, opSlt, opSltu,
    opSh1add, opSh2add, opSh3add,
    opAndn, opOrn, opXnor, opClz, opCtz, opCpop, opMin, opMinu, opMax, opMaxu,
    opSextB, opSextH, opZextH, opRol, opRor, opOrcB, opRev8,
    opClmul, opClmulh, opClmulr,
    opBset, opBclr, opBinv, opBext
  } bmuOpT;

  // Final result source
  typedef enum logic [1:0] {
    alu    = 2'b00,
    zbaZbs = 2'b01,
    zbb    = 2'b10,
    zbc    = 2'b11
  } bSelT;

  //////////////////////////////
  // Base ALU operation codes
  //////////////////////////////
  localparam logic [3:0] aluAdd  = 4'd0;     // Also sub and shNadd
  localparam logic [3:0] aluSll  = 4'd1;
  localparam logic [3:0] aluSlt  = 4'd2;
  localparam logic [3:0] aluSltu = 4'd3;
  localparam logic [3:0] aluXor  = 4'd4;
  localparam logic [3:0] aluSrl  = 4'd5;
  localparam logic [3:0] aluSra  = 4'd6;
  localparam logic [3:0] aluOr   = 4'd7;
  localparam logic [3:0] aluAnd  = 4'd8;
  localparam logic [3:0] aluBset = 4'd9;
  localparam logic [3:0] aluBclr = 4'd10;
  localparam logic [3:0] aluBinv = 4'd11;
  localparam logic [3:0] aluBext = 4'd12;

  // ZBB result groups, sub-select is {rotate, funct3[0]}
  localparam logic [2:0] zbbCount = 3'd0;    // 00 clz, 01 ctz, 1x cpop
  localparam logic [2:0] zbbMin   = 3'd1;
  localparam logic [2:0] zbbMax   = 3'd2;
  localparam logic [2:0] zbbRot   = 3'd3;    // rotate high means rol
  localparam logic [2:0] zbbByte  = 3'd4;    // 0 orc.b, 1 rev8
  localparam logic [2:0] zbbExt   = 3'd5;    // 00 sext.b, 01 sext.h, 1x zext.h
  localparam logic [2:0] zbbLogic = 3'd6;    // 00 andn, 01 orn, 1x xnor

  typedef struct packed {
    bSelT       bSelect;
    logic [2:0] zbbSelect;
    logic [2:0] funct3;
    logic [2:0] bAluControl;                 // {rotate, mask, preShift}
    logic [3:0] aluOp;
    logic       subtract;
  } bmuCtrlT;

  typedef struct packed {
    bmuOpT             op;
    logic [tagW-1:0]   tag;
    logic [maxXlen-1:0] a;
    logic [maxXlen-1:0] b;
  } bmuReqT;

  typedef struct packed {
    logic [tagW-1:0]    tag;
    logic [maxXlen-1:0] result;
  } bmuRespT;

endpackage : bmuOpPkg

`default_nettype wire

// File: src/bmuCfgPkg.sv
// Datapath widths shared by every block of the execute unit
// XLEN is 32 or 64, full-width operations only
`default_nettype none

package bmuCfgPkg;

  localparam int xlenDefault = 32;           // Width built by the top level unless overridden
  localparam int maxXlen     = 64;           // Operand and result fields of the port structs
  localparam int tagW        = 4;            // Request tag travels with the result

endpackage : bmuCfgPkg

`default_nettype wire
